/* src/rf_pkg.sv */
// Register file package
// Sizes, word types and the zero word of the integer register file
// Each stored word carries one even-parity bit per data byte

package rf_pkg;

  // Register array geometry
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Data and check code widths
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned CHECK_W   = 4;
  localparam int unsigned RF_WORD_W = DATA_W + CHECK_W;

  // Register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Stored word, check bits in the top CHECK_W bits
  typedef logic [RF_WORD_W-1:0] rf_word_t;

  // All-zero data has all-zero byte parity
  localparam rf_word_t ZERO_WORD = '0;

endpackage

/* src/icache_pkg.sv */
// Instruction cache package
// Geometry of the tag and data banks, scramble key type and bank payloads

package icache_pkg;

  // Cache geometry
  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 16;
  localparam int unsigned IC_INDEX_W   = 4;

  // Payload widths of the tag and data banks
  localparam int unsigned IC_TAG_W  = 22;
  localparam int unsigned IC_LINE_W = 64;

  // Scramble key width
  localparam int unsigned SCR_KEY_W = 32;

  typedef logic [SCR_KEY_W-1:0]  scr_key_t;
  typedef logic [IC_TAG_W-1:0]   ic_tag_t;
  typedef logic [IC_LINE_W-1:0]  ic_line_t;
  typedef logic [IC_INDEX_W-1:0] ic_index_t;

  // Key in use until the first exchange
  localparam scr_key_t KEY_RESET = 32'h5a3c_96e1;

endpackage

/* src/shell_status.sv */
// Shell status
// Registered busy flag, sleep output and the major internal alert

`timescale 1ns/1ps

module shell_status (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic core_alert_i,
  input  logic rf_err_i,
  output logic core_sleep_o,
  output logic alert_major_internal_o
);

  logic core_busy_q;
  logic clock_en;

  // Busy flag takes effect one clock after the core raises it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake-up terms act without delay
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Register file check error counts as a major internal fault
  assign alert_major_internal_o = core_alert_i | rf_err_i;

endmodule

/* src/reg_file.sv */
// Integer register file
// Flip-flop storage of data and byte parity, two combinational read ports
// and a parity check on each read port

`timescale 1ns/1ps

module reg_file import rf_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  rf_word_t  wdata_i,
  input  logic      we_i,
  output rf_word_t  rdata_a_o,
  output rf_word_t  rdata_b_o,
  output logic      err_o
);

  rf_word_t               rf_reg [NUM_REGS];
  logic [NUM_REGS-1:1]    we_dec;
  logic                   err_a;
  logic                   err_b;

  // Even parity of each data byte
  function automatic logic [CHECK_W-1:0] calc_check(input logic [DATA_W-1:0] data);
    logic [CHECK_W-1:0] check;
    for (int i = 0; i < CHECK_W; i++) begin
      check[i] = ^data[8*i +: 8];
    end
    return check;
  endfunction

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // One-hot write enables, register 0 has none
  always_comb begin
    for (int i = 1; i < NUM_REGS; i++) begin
      we_dec[i] = we_i && (waddr_i == reg_addr_t'(i));
    end
  end

  // Register 0 is hardwired
  assign rf_reg[0] = ZERO_WORD;

  for (genvar i = 1; i < NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= ZERO_WORD;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wdata_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

  // Recompute parity and compare with the stored check bits
  assign err_a = rdata_a_o[RF_WORD_W-1:DATA_W] != calc_check(rdata_a_o[DATA_W-1:0]);
  assign err_b = rdata_b_o[RF_WORD_W-1:DATA_W] != calc_check(rdata_b_o[DATA_W-1:0]);

  assign err_o = err_a | err_b;

endmodule

/* src/scramble_key_ctrl.sv */
// Scramble key control
// Holds the cache scramble key and runs the key request and valid exchange

`timescale 1ns/1ps

module scramble_key_ctrl import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     key_req_i,
  input  logic     key_valid_i,
  input  scr_key_t key_i,
  output scr_key_t key_o,
  output logic     key_valid_o,
  output logic     req_o
);

  scr_key_t key_q;
  logic     key_valid_d;
  logic     key_valid_q;
  logic     req_d;
  logic     req_q;

  // Open request waits for a valid key, otherwise a pulse opens one
  assign req_d = req_q ? ~key_valid_i : key_req_i;

  // Key goes invalid with the request and valid again with the new key
  assign key_valid_d = req_q     ? key_valid_i :
                       key_req_i ? 1'b0        :
                                   key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  // Any valid key from the provider is taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= KEY_RESET;
    end else if (key_valid_i) begin
      key_q <= key_i;
    end
  end

  assign key_o       = key_q;
  assign key_valid_o = key_valid_q;
  assign req_o       = req_q;

endmodule

/* src/icache_bank.sv */
// Scrambled cache RAM bank
// Single-port memory that XORs a keystream on write and on read,
// with a registered read output

`timescale 1ns/1ps

module icache_bank import icache_pkg::*; #(
  parameter int unsigned Depth     = IC_NUM_LINES,
  parameter type         payload_t = ic_line_t
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      write_i,
  input  logic      key_valid_i,
  input  ic_index_t addr_i,
  input  payload_t  wdata_i,
  input  scr_key_t  key_i,
  output payload_t  rdata_o
);

  localparam int unsigned Width = $bits(payload_t);
  localparam int unsigned Reps  = (Width + SCR_KEY_W - 1) / SCR_KEY_W;

  logic [Reps*SCR_KEY_W-1:0] key_rep;
  payload_t                  keystream;
  payload_t                  mem_q [Depth];
  payload_t                  rdata_q;

  // Key repeated up to the payload width, then cut
  assign key_rep   = {Reps{key_i}};
  assign keystream = payload_t'(key_rep[Width-1:0]);

  // Storage
  always_ff @(posedge clk_i) begin
    if (req_i && write_i && key_valid_i) begin
      mem_q[addr_i] <= wdata_i ^ keystream;
    end
  end

  // Read data holds between reads, clears while the key is invalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (!key_valid_i) begin
      rdata_q <= '0;
    end else if (req_i && !write_i) begin
      rdata_q <= mem_q[addr_i] ^ keystream;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* src/cpu_shell_top.sv */
// Integration shell around the processor core
// Sleep control, protected register file, scramble key exchange and
// the scrambled instruction cache tag and data banks

`timescale 1ns/1ps

module cpu_shell_top import rf_pkg::*, icache_pkg::*; #(
  parameter int unsigned NumWays = IC_NUM_WAYS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Core status
  input  logic                 core_busy_i,
  input  logic                 debug_req_i,
  input  logic                 irq_pending_i,
  input  logic                 irq_nm_i,
  input  logic                 core_alert_i,
  output logic                 core_sleep_o,
  output logic                 alert_major_internal_o,

  // Register file
  input  reg_addr_t            rf_raddr_a_i,
  input  reg_addr_t            rf_raddr_b_i,
  input  reg_addr_t            rf_waddr_i,
  input  rf_word_t             rf_wdata_i,
  input  logic                 rf_we_i,
  output rf_word_t             rf_rdata_a_o,
  output rf_word_t             rf_rdata_b_o,

  // Scramble key exchange
  input  logic                 ic_scr_key_req_i,
  input  logic                 scramble_key_valid_i,
  input  scr_key_t             scramble_key_i,
  output logic                 scramble_req_o,
  output logic                 ic_scr_key_valid_o,

  // Instruction cache RAMs
  input  logic [NumWays-1:0]   ic_tag_req_i,
  input  logic [NumWays-1:0]   ic_data_req_i,
  input  logic                 ic_write_i,
  input  ic_index_t            ic_addr_i,
  input  ic_tag_t              ic_tag_wdata_i,
  input  ic_line_t             ic_data_wdata_i,
  output ic_tag_t              ic_tag_rdata_o [NumWays],
  output ic_line_t             ic_data_rdata_o [NumWays]
);

  logic     rf_err;
  scr_key_t scr_key;
  logic     scr_key_valid;

  //////////////////////////////////////////////////
  // Sleep control and alerts
  //////////////////////////////////////////////////

  shell_status u_shell_status (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .core_busy_i            (core_busy_i),
    .debug_req_i            (debug_req_i),
    .irq_pending_i          (irq_pending_i),
    .irq_nm_i               (irq_nm_i),
    .core_alert_i           (core_alert_i),
    .rf_err_i               (rf_err),
    .core_sleep_o           (core_sleep_o),
    .alert_major_internal_o (alert_major_internal_o)
  );

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .waddr_i   (rf_waddr_i),
    .wdata_i   (rf_wdata_i),
    .we_i      (rf_we_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o),
    .err_o     (rf_err)
  );

  //////////////////////////////////////////////////
  // Scramble key
  //////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_req_i   (ic_scr_key_req_i),
    .key_valid_i (scramble_key_valid_i),
    .key_i       (scramble_key_i),
    .key_o       (scr_key),
    .key_valid_o (scr_key_valid),
    .req_o       (scramble_req_o)
  );

  // The core sees the same flag that gates the banks
  assign ic_scr_key_valid_o = scr_key_valid;

  //////////////////////////////////////////////////
  // Cache banks
  //////////////////////////////////////////////////

  for (genvar way = 0; way < NumWays; way++) begin : gen_ways
    // Tag bank
    icache_bank #(
      .Depth     (IC_NUM_LINES),
      .payload_t (ic_tag_t)
    ) u_tag_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (ic_tag_req_i[way]),
      .write_i     (ic_write_i),
      .key_valid_i (scr_key_valid),
      .addr_i      (ic_addr_i),
      .wdata_i     (ic_tag_wdata_i),
      .key_i       (scr_key),
      .rdata_o     (ic_tag_rdata_o[way])
    );

    // Data bank
    icache_bank #(
      .Depth     (IC_NUM_LINES),
      .payload_t (ic_line_t)
    ) u_data_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (ic_data_req_i[way]),
      .write_i     (ic_write_i),
      .key_valid_i (scr_key_valid),
      .addr_i      (ic_addr_i),
      .wdata_i     (ic_data_wdata_i),
      .key_i       (scr_key),
      .rdata_o     (ic_data_rdata_o[way])
    );
  end

endmodule

/* tests/tb_cpu_shell.sv */
// Testbench for the CPU integration shell
// Plays the core and the key provider, checks sleep control, register file
// parity, the key exchange and the scrambled cache banks

`timescale 1ns/1ps

module tb_cpu_shell import rf_pkg::*, icache_pkg::*;;

  localparam int unsigned TIMEOUT_CYCLES = 50;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      core_busy_i, debug_req_i, irq_pending_i, irq_nm_i, core_alert_i;
  logic      core_sleep_o, alert_major_internal_o;
  reg_addr_t rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  rf_word_t  rf_wdata_i;
  logic      rf_we_i;
  rf_word_t  rf_rdata_a_o, rf_rdata_b_o;
  logic      ic_scr_key_req_i, scramble_key_valid_i;
  scr_key_t  scramble_key_i;
  logic      scramble_req_o, ic_scr_key_valid_o;
  logic [IC_NUM_WAYS-1:0] ic_tag_req_i, ic_data_req_i;
  logic      ic_write_i;
  ic_index_t ic_addr_i;
  ic_tag_t   ic_tag_wdata_i;
  ic_line_t  ic_data_wdata_i;
  ic_tag_t   ic_tag_rdata_o [IC_NUM_WAYS];
  ic_line_t  ic_data_rdata_o [IC_NUM_WAYS];

  // Reference state
  logic [31:0] lfsr_state;
  rf_word_t    rf_model [NUM_REGS];
  scr_key_t    cur_key;
  ic_tag_t     tag_plain [IC_NUM_WAYS][IC_NUM_LINES];
  ic_line_t    line_plain [IC_NUM_WAYS][IC_NUM_LINES];
  scr_key_t    line_key [IC_NUM_WAYS][IC_NUM_LINES];
  bit          line_written [IC_NUM_WAYS][IC_NUM_LINES];

  cpu_shell_top #(
    .NumWays (IC_NUM_WAYS)
  ) u_cpu_shell_top (
    .clk_i, .rst_ni,
    .core_busy_i, .debug_req_i, .irq_pending_i, .irq_nm_i, .core_alert_i,
    .core_sleep_o, .alert_major_internal_o,
    .rf_raddr_a_i, .rf_raddr_b_i, .rf_waddr_i, .rf_wdata_i, .rf_we_i,
    .rf_rdata_a_o, .rf_rdata_b_o,
    .ic_scr_key_req_i, .scramble_key_valid_i, .scramble_key_i,
    .scramble_req_o, .ic_scr_key_valid_o,
    .ic_tag_req_i, .ic_data_req_i, .ic_write_i, .ic_addr_i,
    .ic_tag_wdata_i, .ic_data_wdata_i, .ic_tag_rdata_o, .ic_data_rdata_o
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Even parity per data byte, placed above the data
  function automatic rf_word_t make_rf_word(input logic [DATA_W-1:0] data);
    logic [CHECK_W-1:0] par;
    par = '0;
    for (int b = 0; b < CHECK_W; b++) begin
      for (int k = 0; k < 8; k++) begin
        par[b] = par[b] ^ data[8*b+k];
      end
    end
    return {par, data};
  endfunction

  // Key repeated, then cut to the payload width
  function automatic logic [63:0] key_stream(input scr_key_t key, input int unsigned width);
    logic [63:0] ks;
    ks = {key, key};
    if (width < 64) begin
      ks = ks & ((64'd1 << width) - 64'd1);
    end
    return ks;
  endfunction

  task automatic check_eq(input string test_name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", test_name, expected, actual);
      $display("Regression failed");
      $fatal(1, "%s saw a wrong value", test_name);
    end
  endtask

  // Polls the key request at each falling edge
  task automatic wait_key_req(input logic level);
    int unsigned cycles;
    cycles = 0;
    while (scramble_req_o !== level) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Regression failed");
        $fatal(1, "scramble key request never reached the expected level");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input rf_word_t word);
    @(posedge clk_i);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= addr;
    rf_wdata_i <= word;
    @(posedge clk_i);
    rf_we_i <= 1'b0;
    if (addr != '0) begin
      rf_model[addr] = word;
    end
    @(negedge clk_i);
  endtask

  task automatic read_regs(input reg_addr_t addr_a, input reg_addr_t addr_b);
    @(posedge clk_i);
    rf_raddr_a_i <= addr_a;
    rf_raddr_b_i <= addr_b;
    @(negedge clk_i);
  endtask

  // One request to a way, read data is valid on return
  task automatic cache_access(input int way, input logic wr, input ic_index_t idx,
                              input ic_tag_t tag, input ic_line_t line);
    logic [IC_NUM_WAYS-1:0] sel;
    sel = '0;
    sel[way] = 1'b1;
    @(posedge clk_i);
    ic_tag_req_i    <= sel;
    ic_data_req_i   <= sel;
    ic_write_i      <= wr;
    ic_addr_i       <= idx;
    ic_tag_wdata_i  <= tag;
    ic_data_wdata_i <= line;
    @(posedge clk_i);
    ic_tag_req_i  <= '0;
    ic_data_req_i <= '0;
    ic_write_i    <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic write_line(input int way, input ic_index_t idx, input ic_tag_t tag,
                            input ic_line_t line);
    cache_access(way, 1'b1, idx, tag, line);
    tag_plain[way][idx]    = tag;
    line_plain[way][idx]   = line;
    line_key[way][idx]     = cur_key;
    line_written[way][idx] = 1'b1;
  endtask

  // Expected read is the written value with the old keystream swapped for the current one
  task automatic check_cache_contents(input string test_name);
    ic_tag_t  exp_tag;
    ic_line_t exp_line;
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      for (int i = 0; i < IC_NUM_LINES; i++) begin
        if (line_written[w][i]) begin
          cache_access(w, 1'b0, ic_index_t'(i), '0, '0);
          exp_tag  = tag_plain[w][i] ^ ic_tag_t'(key_stream(line_key[w][i], IC_TAG_W)) ^
                     ic_tag_t'(key_stream(cur_key, IC_TAG_W));
          exp_line = line_plain[w][i] ^ ic_line_t'(key_stream(line_key[w][i], IC_LINE_W)) ^
                     ic_line_t'(key_stream(cur_key, IC_LINE_W));
          check_eq(test_name, 64'(exp_tag), 64'(ic_tag_rdata_o[w]));
          check_eq(test_name, 64'(exp_line), 64'(ic_data_rdata_o[w]));
        end
      end
    end
  endtask

  // Acts as the key provider
  task automatic exchange_key(input scr_key_t new_key);
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b1;
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b0;
    @(negedge clk_i);
    wait_key_req(1'b1);
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b1;
    scramble_key_i       <= new_key;
    @(negedge clk_i);
    wait_key_req(1'b0);
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b0;
    @(negedge clk_i);
    cur_key = new_key;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    check_eq("test_reset", 64'(1'b0), 64'(scramble_req_o));
    check_eq("test_reset", 64'(1'b1), 64'(ic_scr_key_valid_o));
    check_eq("test_reset", 64'(1'b1), 64'(core_sleep_o));
    check_eq("test_reset", 64'(1'b0), 64'(alert_major_internal_o));
  endtask

  task automatic test_sleep();
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b0), 64'(core_sleep_o));
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    irq_nm_i    <= 1'b1;
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b0), 64'(core_sleep_o));
    @(posedge clk_i);
    irq_nm_i      <= 1'b0;
    irq_pending_i <= 1'b1;
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b0), 64'(core_sleep_o));
    @(posedge clk_i);
    irq_pending_i <= 1'b0;
    core_busy_i   <= 1'b1;
    @(negedge clk_i);
    // Busy not yet registered
    check_eq("test_sleep", 64'(1'b1), 64'(core_sleep_o));
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b0), 64'(core_sleep_o));
    @(posedge clk_i);
    core_busy_i <= 1'b0;
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b0), 64'(core_sleep_o));
    @(negedge clk_i);
    check_eq("test_sleep", 64'(1'b1), 64'(core_sleep_o));
  endtask

  task automatic test_rf_rw();
    reg_addr_t addr;
    for (int k = 0; k < 10; k++) begin
      addr = reg_addr_t'(rand_bits(REG_ADDR_W));
      write_reg(addr, make_rf_word(DATA_W'(rand_bits(DATA_W))));
      check_eq("test_rf_rw", 64'(1'b0), 64'(alert_major_internal_o));
    end
    write_reg('0, make_rf_word(DATA_W'(rand_bits(DATA_W))));
    for (int i = 0; i < NUM_REGS; i++) begin
      read_regs(reg_addr_t'(i), reg_addr_t'(NUM_REGS - 1 - i));
      check_eq("test_rf_rw", 64'(rf_model[i]), 64'(rf_rdata_a_o));
      check_eq("test_rf_rw", 64'(rf_model[NUM_REGS-1-i]), 64'(rf_rdata_b_o));
      check_eq("test_rf_rw", 64'(1'b0), 64'(alert_major_internal_o));
    end
    read_regs('0, '0);
    check_eq("test_rf_rw", 64'(ZERO_WORD), 64'(rf_rdata_a_o));
    check_eq("test_rf_rw", 64'(ZERO_WORD), 64'(rf_rdata_b_o));
  endtask

  task automatic test_rf_corrupt();
    reg_addr_t addr;
    rf_word_t  good;
    rf_word_t  bad;
    int        flip_bit;
    addr = reg_addr_t'(rand_bits(REG_ADDR_W));
    if (addr == '0) begin
      addr = reg_addr_t'(9);
    end
    good     = make_rf_word(DATA_W'(rand_bits(DATA_W)));
    flip_bit = int'(rand_bits(2));
    bad      = good;
    bad[DATA_W+flip_bit] = ~bad[DATA_W+flip_bit];
    read_regs('0, '0);
    write_reg(addr, bad);
    check_eq("test_rf_corrupt", 64'(1'b0), 64'(alert_major_internal_o));
    read_regs(addr, '0);
    check_eq("test_rf_corrupt", 64'(bad), 64'(rf_rdata_a_o));
    check_eq("test_rf_corrupt", 64'(1'b1), 64'(alert_major_internal_o));
    read_regs('0, addr);
    check_eq("test_rf_corrupt", 64'(1'b1), 64'(alert_major_internal_o));
    read_regs('0, '0);
    check_eq("test_rf_corrupt", 64'(1'b0), 64'(alert_major_internal_o));
    // Core alert alone raises the major alert
    @(posedge clk_i);
    core_alert_i <= 1'b1;
    @(negedge clk_i);
    check_eq("test_rf_corrupt", 64'(1'b1), 64'(alert_major_internal_o));
    @(posedge clk_i);
    core_alert_i <= 1'b0;
    @(negedge clk_i);
    // Repair the word
    write_reg(addr, good);
    read_regs(addr, addr);
    check_eq("test_rf_corrupt", 64'(1'b0), 64'(alert_major_internal_o));
    read_regs('0, '0);
  endtask

  task automatic test_key_exchange();
    ic_tag_t  tag;
    ic_line_t line;
    scr_key_t new_key;
    tag  = ic_tag_t'(rand_bits(IC_TAG_W));
    line = ic_line_t'(rand_bits(IC_LINE_W));
    write_line(0, ic_index_t'(3), tag, line);
    cache_access(0, 1'b0, ic_index_t'(3), '0, '0);
    check_eq("test_key_exchange", 64'(tag), 64'(ic_tag_rdata_o[0]));
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b1;
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b0;
    @(negedge clk_i);
    check_eq("test_key_exchange", 64'(1'b1), 64'(scramble_req_o));
    check_eq("test_key_exchange", 64'(1'b0), 64'(ic_scr_key_valid_o));
    // Both requests must be dropped while the key is invalid
    cache_access(0, 1'b1, ic_index_t'(3), ~tag, ~line);
    cache_access(0, 1'b0, ic_index_t'(3), '0, '0);
    check_eq("test_key_exchange", 64'(0), 64'(ic_tag_rdata_o[0]));
    check_eq("test_key_exchange", 64'(0), 64'(ic_data_rdata_o[0]));
    check_eq("test_key_exchange", 64'(1'b1), 64'(scramble_req_o));
    new_key = scr_key_t'(rand_bits(SCR_KEY_W));
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b1;
    scramble_key_i       <= new_key;
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b0;
    @(negedge clk_i);
    check_eq("test_key_exchange", 64'(1'b0), 64'(scramble_req_o));
    check_eq("test_key_exchange", 64'(1'b1), 64'(ic_scr_key_valid_o));
    cur_key = new_key;
    check_cache_contents("test_key_exchange");
  endtask

  task automatic test_cache_scramble();
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      for (int k = 0; k < 4; k++) begin
        write_line(w, ic_index_t'(rand_bits(IC_INDEX_W)),
                   ic_tag_t'(rand_bits(IC_TAG_W)), ic_line_t'(rand_bits(IC_LINE_W)));
      end
    end
    check_cache_contents("test_cache_scramble");
    exchange_key(scr_key_t'(rand_bits(SCR_KEY_W)));
    check_cache_contents("test_cache_scramble");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni               <= 1'b0;
    core_busy_i          <= 1'b0;
    debug_req_i          <= 1'b0;
    irq_pending_i        <= 1'b0;
    irq_nm_i             <= 1'b0;
    core_alert_i         <= 1'b0;
    rf_raddr_a_i         <= '0;
    rf_raddr_b_i         <= '0;
    rf_waddr_i           <= '0;
    rf_wdata_i           <= '0;
    rf_we_i              <= 1'b0;
    ic_scr_key_req_i     <= 1'b0;
    scramble_key_valid_i <= 1'b0;
    scramble_key_i       <= '0;
    ic_tag_req_i         <= '0;
    ic_data_req_i        <= '0;
    ic_write_i           <= 1'b0;
    ic_addr_i            <= '0;
    ic_tag_wdata_i       <= '0;
    ic_data_wdata_i      <= '0;
    lfsr_state = 32'hca13;
    cur_key    = KEY_RESET;
    for (int i = 0; i < NUM_REGS; i++) begin
      rf_model[i] = ZERO_WORD;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    test_reset();
    test_sleep();
    test_rf_rw();
    test_rf_corrupt();
    test_key_exchange();
    test_cache_scramble();
    $display("Regression passed");
    $finish;
  end

endmodule

/* filelist.f */
src/rf_pkg.sv
src/icache_pkg.sv
src/shell_status.sv
src/reg_file.sv
src/scramble_key_ctrl.sv
src/icache_bank.sv
src/cpu_shell_top.sv
tests/tb_cpu_shell.sv

/* run.sh */
#!/bin/sh
# Compile and run the shell regression with Verilator
# The simulator exits non-zero on $fatal, which set -e turns into a failing status
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_cpu_shell \
  -f filelist.f \
  -o sim_tb_cpu_shell

./obj_dir/sim_tb_cpu_shell
